// File: include/iq_defines.svh
`ifndef IQ_DEFINES_SVH
`define IQ_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// queue geometry
////////////////////////////////////////////////////////////////////////////

`define IQ_DEPTH        16
`define IQ_PTR_W        4
`define IQ_CNT_W        5     // holds 0..IQ_DEPTH
`define IQ_FULL_MARGIN  8     // free slots upstream keeps in hand

////////////////////////////////////////////////////////////////////////////
// decoded instruction fields
////////////////////////////////////////////////////////////////////////////

`define XLEN            32
`define REG_AW          5
`define ALU_OP_W        12    // one-hot
`define CSR_AW          14
`define ECODE_W         7

`endif

// File: logic/iq_entry_pkg.sv
`include "iq_defines.svh"

package iq_entry_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bit layout of one queue entry word, lsb first
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned PC_LSB     = 0;
    localparam int unsigned INSTR_LSB  = PC_LSB + `XLEN;
    localparam int unsigned IMM_LSB    = INSTR_LSB + `XLEN;
    localparam int unsigned RD_LSB     = IMM_LSB + `XLEN;
    localparam int unsigned RF_WE_BIT  = RD_LSB + `REG_AW;
    localparam int unsigned RA1_LSB    = RF_WE_BIT + 1;
    localparam int unsigned RA2_LSB    = RA1_LSB + `REG_AW;
    localparam int unsigned ALU_OP_LSB = RA2_LSB + `REG_AW;
    localparam int unsigned CSR_LSB    = ALU_OP_LSB + `ALU_OP_W;
    localparam int unsigned EXC_V_BIT  = CSR_LSB + `CSR_AW;
    localparam int unsigned ECODE_LSB  = EXC_V_BIT + 1;

    // ecode sits on top
    localparam int unsigned IQ_ENTRY_W = ECODE_LSB + `ECODE_W;

endpackage

// File: logic/iq_ptr_pkg.sv
`include "iq_defines.svh"

package iq_ptr_pkg;

    localparam logic [`IQ_PTR_W:0] DEPTH_EXT = `IQ_DEPTH;

    // ring increment by 0..2, wraps without relying on a power-of-two depth
    function automatic logic [`IQ_PTR_W-1:0] ptr_add(
        input logic [`IQ_PTR_W-1:0] ptr,
        input logic [1:0]           inc
    );
        logic [`IQ_PTR_W:0] sum;
        sum = {1'b0, ptr} + {{(`IQ_PTR_W-1){1'b0}}, inc};
        if (sum >= DEPTH_EXT) begin
            sum = sum - DEPTH_EXT;
        end
        return sum[`IQ_PTR_W-1:0];
    endfunction

    // bit 0 is the oldest slot
    function automatic logic [1:0] valid_mask(
        input logic [`IQ_CNT_W-1:0] cnt
    );
        logic [1:0] mask;
        if (cnt == '0) begin
            mask = 2'b00;
        end else if (cnt == 1) begin
            mask = 2'b01;
        end else begin
            mask = 2'b11;
        end
        return mask;
    endfunction

endpackage

// File: logic/iq_storage.sv
`timescale 1ns/1ns
`include "iq_defines.svh"

module iq_storage
    import iq_entry_pkg::*;
(
    input  logic                   clk,

    input  logic                   i_wr_en0,
    input  logic                   i_wr_en1,
    input  logic [`IQ_PTR_W-1:0]   i_wr_addr0,
    input  logic [`IQ_PTR_W-1:0]   i_wr_addr1,
    input  logic [IQ_ENTRY_W-1:0]  i_wr_data0,
    input  logic [IQ_ENTRY_W-1:0]  i_wr_data1,

    input  logic [`IQ_PTR_W-1:0]   i_rd_addr0,
    input  logic [`IQ_PTR_W-1:0]   i_rd_addr1,
    output logic [IQ_ENTRY_W-1:0]  o_rd_data0,
    output logic [IQ_ENTRY_W-1:0]  o_rd_data1
);

    logic [IQ_ENTRY_W-1:0] mem [`IQ_DEPTH];

    ////////////////////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////////////////////

    // addresses are head and head+1, never equal
    always_ff @(posedge clk) begin
        if (i_wr_en0) begin
            mem[i_wr_addr0] <= i_wr_data0;
        end
        if (i_wr_en1) begin
            mem[i_wr_addr1] <= i_wr_data1;   // slot 1 payload
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////////////////////

    assign o_rd_data0 = mem[i_rd_addr0];    // oldest
    assign o_rd_data1 = mem[i_rd_addr1];

endmodule

// File: logic/iq_ctrl.sv
`timescale 1ns/1ns
`include "iq_defines.svh"

module iq_ctrl
    import iq_ptr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,

    input  logic                  i_s0_valid,
    input  logic                  i_s1_valid,
    input  logic                  i_flush,
    input  logic                  i_stall,
    input  logic [1:0]            i_use_num,

    output logic                  o_wr_en0,
    output logic                  o_wr_en1,
    output logic [`IQ_PTR_W-1:0]  o_wr_addr0,
    output logic [`IQ_PTR_W-1:0]  o_wr_addr1,
    output logic [`IQ_PTR_W-1:0]  o_rd_addr0,
    output logic [`IQ_PTR_W-1:0]  o_rd_addr1,

    output logic [1:0]            o_valid,
    output logic                  o_full
);

    localparam logic [`IQ_CNT_W-1:0] FULL_LEVEL = `IQ_DEPTH - `IQ_FULL_MARGIN;

    logic [`IQ_PTR_W-1:0] head;     // next write slot
    logic [`IQ_PTR_W-1:0] tail;     // oldest entry
    logic [`IQ_CNT_W-1:0] count;
    logic [`IQ_CNT_W-1:0] next_count;
    logic [`IQ_CNT_W-1:0] wr_num;
    logic [`IQ_CNT_W-1:0] use_num;
    logic                 wr_en0;
    logic                 wr_en1;
    logic [1:0]           valid_q;
    logic                 full_q;

    ////////////////////////////////////////////////////////////////////////////
    // write enables and counts
    ////////////////////////////////////////////////////////////////////////////

    assign wr_en0 = i_s0_valid & ~i_flush;
    assign wr_en1 = i_s0_valid & i_s1_valid & ~i_flush;   // slot 1 rides on slot 0

    assign wr_num  = {{(`IQ_CNT_W-2){1'b0}}, wr_en1, wr_en0 & ~wr_en1};
    assign use_num = i_stall ? '0 : {{(`IQ_CNT_W-2){1'b0}}, i_use_num};

    assign next_count = count - use_num + wr_num;

    assign o_wr_en0   = wr_en0;
    assign o_wr_en1   = wr_en1;
    assign o_wr_addr0 = head;
    assign o_wr_addr1 = ptr_add(head, 2'd1);

    assign o_rd_addr0 = tail;
    assign o_rd_addr1 = ptr_add(tail, 2'd1);

    ////////////////////////////////////////////////////////////////////////////
    // pointers, occupancy and registered flags
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            valid_q <= 2'b00;
            full_q  <= 1'b0;
        end else if (i_flush) begin
            head    <= '0;   // writes this cycle are dropped
            tail    <= '0;
            count   <= '0;
            valid_q <= 2'b00;
            full_q  <= 1'b0;
        end else begin
            head    <= ptr_add(head, wr_num[1:0]);
            tail    <= ptr_add(tail, use_num[1:0]);   // frozen under stall
            count   <= next_count;
            valid_q <= valid_mask(next_count);
            full_q  <= (next_count >= FULL_LEVEL);
        end
    end

    assign o_valid = valid_q;
    assign o_full  = full_q;

endmodule

// File: logic/inst_queue.sv
`timescale 1ns/1ns
`include "iq_defines.svh"

module inst_queue
    import iq_entry_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_flush,
    input  logic                  i_stall,
    input  logic [1:0]            i_use_num,

    // write slot 0
    input  logic                  i_s0_valid,
    input  logic [`XLEN-1:0]      i_s0_pc,
    input  logic [`XLEN-1:0]      i_s0_instr,
    input  logic [`XLEN-1:0]      i_s0_imm,
    input  logic [`REG_AW-1:0]    i_s0_rd,
    input  logic                  i_s0_rf_we,
    input  logic [`REG_AW-1:0]    i_s0_ra1,
    input  logic [`REG_AW-1:0]    i_s0_ra2,
    input  logic [`ALU_OP_W-1:0]  i_s0_alu_op,
    input  logic [`CSR_AW-1:0]    i_s0_csr_addr,
    input  logic                  i_s0_exc_v,
    input  logic [`ECODE_W-1:0]   i_s0_ecode,

    // write slot 1
    input  logic                  i_s1_valid,
    input  logic [`XLEN-1:0]      i_s1_pc,
    input  logic [`XLEN-1:0]      i_s1_instr,
    input  logic [`XLEN-1:0]      i_s1_imm,
    input  logic [`REG_AW-1:0]    i_s1_rd,
    input  logic                  i_s1_rf_we,
    input  logic [`REG_AW-1:0]    i_s1_ra1,
    input  logic [`REG_AW-1:0]    i_s1_ra2,
    input  logic [`ALU_OP_W-1:0]  i_s1_alu_op,
    input  logic [`CSR_AW-1:0]    i_s1_csr_addr,
    input  logic                  i_s1_exc_v,
    input  logic [`ECODE_W-1:0]   i_s1_ecode,

    // issue slot 0, oldest
    output logic [`XLEN-1:0]      o_s0_pc,
    output logic [`XLEN-1:0]      o_s0_instr,
    output logic [`XLEN-1:0]      o_s0_imm,
    output logic [`REG_AW-1:0]    o_s0_rd,
    output logic                  o_s0_rf_we,
    output logic [`REG_AW-1:0]    o_s0_ra1,
    output logic [`REG_AW-1:0]    o_s0_ra2,
    output logic [`ALU_OP_W-1:0]  o_s0_alu_op,
    output logic [`CSR_AW-1:0]    o_s0_csr_addr,
    output logic                  o_s0_exc_v,
    output logic [`ECODE_W-1:0]   o_s0_ecode,

    // issue slot 1
    output logic [`XLEN-1:0]      o_s1_pc,
    output logic [`XLEN-1:0]      o_s1_instr,
    output logic [`XLEN-1:0]      o_s1_imm,
    output logic [`REG_AW-1:0]    o_s1_rd,
    output logic                  o_s1_rf_we,
    output logic [`REG_AW-1:0]    o_s1_ra1,
    output logic [`REG_AW-1:0]    o_s1_ra2,
    output logic [`ALU_OP_W-1:0]  o_s1_alu_op,
    output logic [`CSR_AW-1:0]    o_s1_csr_addr,
    output logic                  o_s1_exc_v,
    output logic [`ECODE_W-1:0]   o_s1_ecode,

    output logic [1:0]            o_valid,
    output logic                  o_full
);

    logic                  wr_en0;
    logic                  wr_en1;
    logic [`IQ_PTR_W-1:0]  wr_addr0;
    logic [`IQ_PTR_W-1:0]  wr_addr1;
    logic [`IQ_PTR_W-1:0]  rd_addr0;
    logic [`IQ_PTR_W-1:0]  rd_addr1;
    logic [IQ_ENTRY_W-1:0] wr_data0;
    logic [IQ_ENTRY_W-1:0] wr_data1;
    logic [IQ_ENTRY_W-1:0] rd_data0;
    logic [IQ_ENTRY_W-1:0] rd_data1;

    ////////////////////////////////////////////////////////////////////////////
    // pack write slots
    ////////////////////////////////////////////////////////////////////////////

    assign wr_data0[PC_LSB +: `XLEN]        = i_s0_pc;
    assign wr_data0[INSTR_LSB +: `XLEN]     = i_s0_instr;
    assign wr_data0[IMM_LSB +: `XLEN]       = i_s0_imm;
    assign wr_data0[RD_LSB +: `REG_AW]      = i_s0_rd;
    assign wr_data0[RF_WE_BIT]              = i_s0_rf_we;
    assign wr_data0[RA1_LSB +: `REG_AW]     = i_s0_ra1;
    assign wr_data0[RA2_LSB +: `REG_AW]     = i_s0_ra2;
    assign wr_data0[ALU_OP_LSB +: `ALU_OP_W] = i_s0_alu_op;
    assign wr_data0[CSR_LSB +: `CSR_AW]     = i_s0_csr_addr;
    assign wr_data0[EXC_V_BIT]              = i_s0_exc_v;
    assign wr_data0[ECODE_LSB +: `ECODE_W]  = i_s0_ecode;

    assign wr_data1[PC_LSB +: `XLEN]        = i_s1_pc;
    assign wr_data1[INSTR_LSB +: `XLEN]     = i_s1_instr;
    assign wr_data1[IMM_LSB +: `XLEN]       = i_s1_imm;
    assign wr_data1[RD_LSB +: `REG_AW]      = i_s1_rd;
    assign wr_data1[RF_WE_BIT]              = i_s1_rf_we;
    assign wr_data1[RA1_LSB +: `REG_AW]     = i_s1_ra1;
    assign wr_data1[RA2_LSB +: `REG_AW]     = i_s1_ra2;
    assign wr_data1[ALU_OP_LSB +: `ALU_OP_W] = i_s1_alu_op;
    assign wr_data1[CSR_LSB +: `CSR_AW]     = i_s1_csr_addr;
    assign wr_data1[EXC_V_BIT]              = i_s1_exc_v;
    assign wr_data1[ECODE_LSB +: `ECODE_W]  = i_s1_ecode;

    ////////////////////////////////////////////////////////////////////////////
    // unpack issue slots
    ////////////////////////////////////////////////////////////////////////////

    assign o_s0_pc       = rd_data0[PC_LSB +: `XLEN];
    assign o_s0_instr    = rd_data0[INSTR_LSB +: `XLEN];
    assign o_s0_imm      = rd_data0[IMM_LSB +: `XLEN];
    assign o_s0_rd       = rd_data0[RD_LSB +: `REG_AW];
    assign o_s0_rf_we    = rd_data0[RF_WE_BIT];
    assign o_s0_ra1      = rd_data0[RA1_LSB +: `REG_AW];
    assign o_s0_ra2      = rd_data0[RA2_LSB +: `REG_AW];
    assign o_s0_alu_op   = rd_data0[ALU_OP_LSB +: `ALU_OP_W];
    assign o_s0_csr_addr = rd_data0[CSR_LSB +: `CSR_AW];
    assign o_s0_exc_v    = rd_data0[EXC_V_BIT];
    assign o_s0_ecode    = rd_data0[ECODE_LSB +: `ECODE_W];

    assign o_s1_pc       = rd_data1[PC_LSB +: `XLEN];
    assign o_s1_instr    = rd_data1[INSTR_LSB +: `XLEN];
    assign o_s1_imm      = rd_data1[IMM_LSB +: `XLEN];
    assign o_s1_rd       = rd_data1[RD_LSB +: `REG_AW];
    assign o_s1_rf_we    = rd_data1[RF_WE_BIT];
    assign o_s1_ra1      = rd_data1[RA1_LSB +: `REG_AW];
    assign o_s1_ra2      = rd_data1[RA2_LSB +: `REG_AW];
    assign o_s1_alu_op   = rd_data1[ALU_OP_LSB +: `ALU_OP_W];
    assign o_s1_csr_addr = rd_data1[CSR_LSB +: `CSR_AW];
    assign o_s1_exc_v    = rd_data1[EXC_V_BIT];
    assign o_s1_ecode    = rd_data1[ECODE_LSB +: `ECODE_W];

    iq_storage u_storage (
        .clk        (clk),
        .i_wr_en0   (wr_en0),
        .i_wr_en1   (wr_en1),
        .i_wr_addr0 (wr_addr0),
        .i_wr_addr1 (wr_addr1),
        .i_wr_data0 (wr_data0),
        .i_wr_data1 (wr_data1),
        .i_rd_addr0 (rd_addr0),
        .i_rd_addr1 (rd_addr1),
        .o_rd_data0 (rd_data0),
        .o_rd_data1 (rd_data1)
    );

    iq_ctrl u_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .i_s0_valid (i_s0_valid),
        .i_s1_valid (i_s1_valid),
        .i_flush    (i_flush),
        .i_stall    (i_stall),
        .i_use_num  (i_use_num),
        .o_wr_en0   (wr_en0),
        .o_wr_en1   (wr_en1),
        .o_wr_addr0 (wr_addr0),
        .o_wr_addr1 (wr_addr1),
        .o_rd_addr0 (rd_addr0),
        .o_rd_addr1 (rd_addr1),
        .o_valid    (o_valid),
        .o_full     (o_full)
    );

endmodule

// File: dv/tb_inst_queue.sv
`timescale 1ns/1ns
`include "iq_defines.svh"

module tb_inst_queue;

    localparam int CLK_PERIOD  = 8;
    localparam int MAX_CYCLES  = 3000;
    localparam int WATCHDOG_NS = MAX_CYCLES * CLK_PERIOD * 11 / 10;
    localparam int FULL_LEVEL  = `IQ_DEPTH - `IQ_FULL_MARGIN;
    localparam int RAND_CYCLES = 2400;

    typedef struct packed {
        logic [`XLEN-1:0]     pc;
        logic [`XLEN-1:0]     instr;
        logic [`XLEN-1:0]     imm;
        logic [`REG_AW-1:0]   rd;
        logic                 rf_we;
        logic [`REG_AW-1:0]   ra1;
        logic [`REG_AW-1:0]   ra2;
        logic [`ALU_OP_W-1:0] alu_op;
        logic [`CSR_AW-1:0]   csr_addr;
        logic                 exc_v;
        logic [`ECODE_W-1:0]  ecode;
    } entry_t;

    logic       clk;
    logic       rstn;
    logic       flush;
    logic       stall;
    logic [1:0] use_num;
    logic       s0_valid;
    logic       s1_valid;
    entry_t     s0_in;
    entry_t     s1_in;
    entry_t     out0;
    entry_t     out1;
    logic [1:0] o_valid;
    logic       o_full;

    entry_t model[$];       // oldest at index 0
    int     errors;
    int     checks;
    int     cycle_cnt;

    inst_queue inst_queue_inst (
        .clk           (clk),
        .rstn          (rstn),
        .i_flush       (flush),
        .i_stall       (stall),
        .i_use_num     (use_num),
        .i_s0_valid    (s0_valid),
        .i_s0_pc       (s0_in.pc),
        .i_s0_instr    (s0_in.instr),
        .i_s0_imm      (s0_in.imm),
        .i_s0_rd       (s0_in.rd),
        .i_s0_rf_we    (s0_in.rf_we),
        .i_s0_ra1      (s0_in.ra1),
        .i_s0_ra2      (s0_in.ra2),
        .i_s0_alu_op   (s0_in.alu_op),
        .i_s0_csr_addr (s0_in.csr_addr),
        .i_s0_exc_v    (s0_in.exc_v),
        .i_s0_ecode    (s0_in.ecode),
        .i_s1_valid    (s1_valid),
        .i_s1_pc       (s1_in.pc),
        .i_s1_instr    (s1_in.instr),
        .i_s1_imm      (s1_in.imm),
        .i_s1_rd       (s1_in.rd),
        .i_s1_rf_we    (s1_in.rf_we),
        .i_s1_ra1      (s1_in.ra1),
        .i_s1_ra2      (s1_in.ra2),
        .i_s1_alu_op   (s1_in.alu_op),
        .i_s1_csr_addr (s1_in.csr_addr),
        .i_s1_exc_v    (s1_in.exc_v),
        .i_s1_ecode    (s1_in.ecode),
        .o_s0_pc       (out0.pc),
        .o_s0_instr    (out0.instr),
        .o_s0_imm      (out0.imm),
        .o_s0_rd       (out0.rd),
        .o_s0_rf_we    (out0.rf_we),
        .o_s0_ra1      (out0.ra1),
        .o_s0_ra2      (out0.ra2),
        .o_s0_alu_op   (out0.alu_op),
        .o_s0_csr_addr (out0.csr_addr),
        .o_s0_exc_v    (out0.exc_v),
        .o_s0_ecode    (out0.ecode),
        .o_s1_pc       (out1.pc),
        .o_s1_instr    (out1.instr),
        .o_s1_imm      (out1.imm),
        .o_s1_rd       (out1.rd),
        .o_s1_rf_we    (out1.rf_we),
        .o_s1_ra1      (out1.ra1),
        .o_s1_ra2      (out1.ra2),
        .o_s1_alu_op   (out1.alu_op),
        .o_s1_csr_addr (out1.csr_addr),
        .o_s1_exc_v    (out1.exc_v),
        .o_s1_ecode    (out1.ecode),
        .o_valid       (o_valid),
        .o_full        (o_full)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model and stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic entry_t random_entry();
        entry_t               e;
        logic [31:0]          r;
        logic [`ALU_OP_W-1:0] one_hot;
        e.pc     = $urandom;
        e.instr  = $urandom;
        e.imm    = $urandom;
        r        = $urandom;
        e.rd     = r[`REG_AW-1:0];
        r        = r >> `REG_AW;
        e.ra1    = r[`REG_AW-1:0];
        r        = r >> `REG_AW;
        e.ra2    = r[`REG_AW-1:0];
        r        = r >> `REG_AW;
        e.rf_we  = r[0];
        e.exc_v  = r[1];
        r        = r >> 2;
        e.ecode  = r[`ECODE_W-1:0];
        r        = $urandom;
        e.csr_addr = r[`CSR_AW-1:0];
        one_hot  = 1;
        e.alu_op = one_hot << ($urandom % `ALU_OP_W);   // one hot
        return e;
    endfunction

    // applies what the DUT saw at this edge
    task automatic model_step();
        int take;
        cycle_cnt++;
        if (!rstn || flush) begin
            model.delete();     // same-cycle writes are lost too
        end else begin
            take = stall ? 0 : int'(use_num);
            repeat (take) begin
                if (model.size() > 0) begin
                    void'(model.pop_front());
                end
            end
            if (s0_valid) begin
                model.push_back(s0_in);
            end
            if (s0_valid && s1_valid) begin
                model.push_back(s1_in);
            end
        end
    endtask

    task automatic drive_cycle(input int wr_cnt, input int take, input bit st, input bit fl);
        s0_valid <= (wr_cnt >= 1);
        s1_valid <= (wr_cnt == 2);
        s0_in    <= random_entry();
        s1_in    <= random_entry();
        use_num  <= take[1:0];
        stall    <= st;
        flush    <= fl;
        @(posedge clk);
        model_step();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        checks++;
        assert (act_v == exp_v) else begin
            $display("ERROR %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
            errors++;
        end
    endtask

    task automatic check_slot(input int slot, input entry_t exp_e, input entry_t act_e);
        check_field($sformatf("o_s%0d_pc", slot), exp_e.pc, act_e.pc);
        check_field($sformatf("o_s%0d_instr", slot), exp_e.instr, act_e.instr);
        check_field($sformatf("o_s%0d_imm", slot), exp_e.imm, act_e.imm);
        check_field($sformatf("o_s%0d_rd", slot), 32'(exp_e.rd), 32'(act_e.rd));
        check_field($sformatf("o_s%0d_rf_we", slot), 32'(exp_e.rf_we), 32'(act_e.rf_we));
        check_field($sformatf("o_s%0d_ra1", slot), 32'(exp_e.ra1), 32'(act_e.ra1));
        check_field($sformatf("o_s%0d_ra2", slot), 32'(exp_e.ra2), 32'(act_e.ra2));
        check_field($sformatf("o_s%0d_alu_op", slot), 32'(exp_e.alu_op), 32'(act_e.alu_op));
        check_field($sformatf("o_s%0d_csr_addr", slot), 32'(exp_e.csr_addr),
                    32'(act_e.csr_addr));
        check_field($sformatf("o_s%0d_exc_v", slot), 32'(exp_e.exc_v), 32'(act_e.exc_v));
        check_field($sformatf("o_s%0d_ecode", slot), 32'(exp_e.ecode), 32'(act_e.ecode));
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        logic [1:0] exp_valid;
        logic       exp_full;
        if (cycle_cnt > 0) begin
            if (model.size() == 0) begin
                exp_valid = 2'b00;
            end else if (model.size() == 1) begin
                exp_valid = 2'b01;
            end else begin
                exp_valid = 2'b11;
            end
            exp_full = (model.size() >= FULL_LEVEL);
            check_field("o_valid", 32'(exp_valid), 32'(o_valid));
            check_field("o_full", 32'(exp_full), 32'(o_full));
            if (exp_valid[0]) begin
                check_slot(0, model[0], out0);
            end
            if (exp_valid[1]) begin
                check_slot(1, model[1], out1);
            end
        end
    end

    a_clear_after_flush: assert property (
        @(posedge clk) (!rstn || flush) |=> (o_valid == 2'b00 && !o_full)
    ) else begin
        $display("ERROR o_valid/o_full after reset or flush expected 0/0 actual %h/%h",
                 o_valid, o_full);
        errors++;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int wr;
        int take;
        int avail;
        bit st;
        bit fl;
        void'($urandom(87));
        rstn      = 1'b0;
        flush     = 1'b0;
        stall     = 1'b0;
        use_num   = 2'd0;
        s0_valid  = 1'b0;
        s1_valid  = 1'b0;
        s0_in     = '0;
        s1_in     = '0;
        errors    = 0;
        checks    = 0;
        cycle_cnt = 0;

        repeat (4) begin
            @(posedge clk);
            model_step();
        end
        rstn <= 1'b1;

        // single-wide fill up to the full level, then drain one by one
        while (model.size() < FULL_LEVEL) drive_cycle(1, 0, 0, 0);
        repeat (2) drive_cycle(0, 0, 0, 0);
        while (model.size() > 0) drive_cycle(0, 1, 0, 0);
        drive_cycle(0, 0, 0, 0);

        // two-wide writes, then stall while still writing
        repeat (2) drive_cycle(2, 0, 0, 0);
        repeat (2) drive_cycle(2, 2, 1, 0);
        while (model.size() > 0) drive_cycle(0, (model.size() > 1) ? 2 : 1, 0, 0);

        // flush with a write in the same cycle, then a fresh entry
        repeat (2) drive_cycle(2, 0, 0, 0);
        drive_cycle(2, 0, 0, 1);
        drive_cycle(1, 0, 0, 0);
        drive_cycle(0, 0, 0, 0);
        drive_cycle(0, 1, 0, 0);

        repeat (RAND_CYCLES) begin
            fl    = (($urandom % 40) == 0);
            st    = (($urandom % 8) == 0);
            wr    = (model.size() < FULL_LEVEL) ? int'($urandom % 3) : 0;
            avail = (model.size() > 2) ? 2 : model.size();
            take  = st ? int'($urandom % 3) : int'($urandom % (avail + 1));
            drive_cycle(wr, take, st, fl);
        end
        repeat (3) drive_cycle(0, 0, 0, 0);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the test did not finish", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
logic/iq_entry_pkg.sv
logic/iq_ptr_pkg.sv
logic/iq_storage.sv
logic/iq_ctrl.sv
logic/inst_queue.sv
dv/tb_inst_queue.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_inst_queue
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
